//--- logic/alu_pkg.sv
package alu_pkg;

    // Operand and result width
    localparam int ALU_WIDTH = 32;

    typedef enum logic [3:0] {
        OP_ADD = 4'd0,
        OP_SUB = 4'd1,
        OP_AND = 4'd2,
        OP_OR  = 4'd3,
        OP_XOR = 4'd4,
        OP_NOT = 4'd5,
        OP_EQ  = 4'd6,
        OP_LT  = 4'd7,
        OP_GT  = 4'd8
    } alu_op_e;

    // Anything above this is rejected on write
    localparam alu_op_e ALU_OP_LAST = OP_GT;

    // Zero lands in bit 0, overflow in bit 1
    typedef struct packed {
        logic overflow;
        logic zero;
    } alu_flags_t;

endpackage

//--- logic/axil_pkg.sv
package axil_pkg;

    localparam int AXIL_ADDR_W = 8;
    localparam int AXIL_DATA_W = 32;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_e;

    // Register map
    localparam logic [AXIL_ADDR_W-1:0] REG_A      = 8'h00;
    localparam logic [AXIL_ADDR_W-1:0] REG_B      = 8'h04;
    localparam logic [AXIL_ADDR_W-1:0] REG_OP     = 8'h08;
    localparam logic [AXIL_ADDR_W-1:0] REG_RESULT = 8'h0C;
    localparam logic [AXIL_ADDR_W-1:0] REG_STATUS = 8'h10;

endpackage

//--- logic/reg_bus_if.sv
`timescale 1ns/1ps

interface reg_bus_if
    import axil_pkg::*;
();

    // Write side, one-cycle strobe
    logic                     wr_en;
    logic [AXIL_ADDR_W-1:0]   wr_addr;
    logic [AXIL_DATA_W-1:0]   wr_data;
    logic [AXIL_DATA_W/8-1:0] wr_strb;
    logic                     wr_err;

    // Read side, answered in the same cycle
    logic                     rd_en;
    logic [AXIL_ADDR_W-1:0]   rd_addr;
    logic [AXIL_DATA_W-1:0]   rd_data;
    logic                     rd_err;

    modport host (
        output wr_en, wr_addr, wr_data, wr_strb, rd_en, rd_addr,
        input  wr_err, rd_data, rd_err
    );

    modport dev (
        input  wr_en, wr_addr, wr_data, wr_strb, rd_en, rd_addr,
        output wr_err, rd_data, rd_err
    );

endinterface

//--- logic/axil_slave.sv
`timescale 1ns/1ps

module axil_slave
    import axil_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,

    // Write address and data
    input  logic [AXIL_ADDR_W-1:0]   awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [AXIL_DATA_W-1:0]   wdata,
    input  logic [AXIL_DATA_W/8-1:0] wstrb,
    input  logic                     wvalid,
    output logic                     wready,

    // Write response
    output axil_resp_e               bresp,
    output logic                     bvalid,
    input  logic                     bready,

    // Read address and data
    input  logic [AXIL_ADDR_W-1:0]   araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output logic [AXIL_DATA_W-1:0]   rdata,
    output axil_resp_e               rresp,
    output logic                     rvalid,
    input  logic                     rready,

    reg_bus_if.host                  bus
);

    logic wr_go;
    logic rd_go;

    // Address and data taken together, only with no response pending
    assign wr_go   = awvalid && wvalid && !bvalid;
    assign awready = wr_go;
    assign wready  = wr_go;

    assign rd_go   = arvalid && !rvalid;
    assign arready = rd_go;

    assign bus.wr_en   = wr_go;
    assign bus.wr_addr = awaddr;
    assign bus.wr_data = wdata;
    assign bus.wr_strb = wstrb;

    assign bus.rd_en   = rd_go;
    assign bus.rd_addr = araddr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bvalid <= 1'b0;
        end else if (wr_go) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_go) begin
            bresp <= bus.wr_err ? SLVERR : OKAY;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (rd_go) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // Read data captured at the strobe
    always_ff @(posedge clk) begin
        if (rd_go) begin
            rdata <= bus.rd_data;
            rresp <= bus.rd_err ? SLVERR : OKAY;
        end
    end

    a_bvalid_hold: assert property (
        @(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp)
    );

    a_rvalid_hold: assert property (
        @(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
    );

endmodule

//--- logic/alu_regs.sv
`timescale 1ns/1ps

module alu_regs
    import alu_pkg::*, axil_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    reg_bus_if.dev               bus,
    output logic                 start,
    output logic [ALU_WIDTH-1:0] a,
    output logic [ALU_WIDTH-1:0] b,
    output alu_op_e              op,
    input  logic [ALU_WIDTH-1:0] result,
    input  alu_flags_t           flags
);

    alu_op_e op_q;
    logic    wr_a;
    logic    wr_b;
    logic    op_ok;

    assign wr_a  = bus.wr_en && (bus.wr_addr == REG_A);
    assign wr_b  = bus.wr_en && (bus.wr_addr == REG_B);

    // Opcode lives in byte 0, so that lane has to be enabled
    assign op_ok = bus.wr_strb[0] && (bus.wr_data[3:0] <= ALU_OP_LAST);
    assign start = bus.wr_en && (bus.wr_addr == REG_OP) && op_ok;

    // Core samples the incoming opcode on the launch edge
    assign op = start ? alu_op_e'(bus.wr_data[3:0]) : op_q;

    always_comb begin
        case (bus.wr_addr)
            REG_A, REG_B: bus.wr_err = 1'b0;
            REG_OP:       bus.wr_err = !op_ok;
            default:      bus.wr_err = 1'b1;
        endcase
    end

    always_comb begin
        bus.rd_data = '0;
        bus.rd_err  = 1'b0;
        if (bus.rd_en) begin
            case (bus.rd_addr)
                REG_A:      bus.rd_data = a;
                REG_B:      bus.rd_data = b;
                REG_OP:     bus.rd_data = AXIL_DATA_W'(op_q);
                REG_RESULT: bus.rd_data = result;
                REG_STATUS: bus.rd_data = AXIL_DATA_W'(flags);
                default:    bus.rd_err  = 1'b1;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            a    <= '0;
            b    <= '0;
            op_q <= OP_ADD;
        end else begin
            // Byte lane merge
            for (int i = 0; i < AXIL_DATA_W/8; i++) begin
                if (wr_a && bus.wr_strb[i]) begin
                    a[i*8 +: 8] <= bus.wr_data[i*8 +: 8];
                end
                if (wr_b && bus.wr_strb[i]) begin
                    b[i*8 +: 8] <= bus.wr_data[i*8 +: 8];
                end
            end
            if (start) begin
                op_q <= op;
            end
        end
    end

    // A launch only comes from a write that is answered OKAY
    a_start_from_op_write: assert property (
        @(posedge clk) disable iff (rst)
        start |-> bus.wr_en && !bus.wr_err
    );

endmodule

//--- logic/alu_core.sv
`timescale 1ns/1ps

module alu_core
    import alu_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic [ALU_WIDTH-1:0] a,
    input  logic [ALU_WIDTH-1:0] b,
    input  alu_op_e              op,
    output logic [ALU_WIDTH-1:0] result,
    output alu_flags_t           flags
);

    logic [ALU_WIDTH-1:0] sum;
    logic [ALU_WIDTH-1:0] diff;
    logic [ALU_WIDTH-1:0] alu_res;
    logic                 alu_ovf;

    assign sum  = a + b;
    assign diff = a - b;

    always_comb begin
        alu_ovf = 1'b0;
        case (op)
            OP_ADD: begin
                alu_res = sum;
                // Same-sign inputs, result sign flipped
                alu_ovf = (a[ALU_WIDTH-1] == b[ALU_WIDTH-1])
                       && (sum[ALU_WIDTH-1] != a[ALU_WIDTH-1]);
            end
            OP_SUB: begin
                alu_res = diff;
                alu_ovf = (a[ALU_WIDTH-1] != b[ALU_WIDTH-1])
                       && (diff[ALU_WIDTH-1] != a[ALU_WIDTH-1]);
            end
            OP_AND:  alu_res = a & b;
            OP_OR:   alu_res = a | b;
            OP_XOR:  alu_res = a ^ b;
            OP_NOT:  alu_res = ~a;
            OP_EQ:   alu_res = ALU_WIDTH'(a == b);
            OP_LT:   alu_res = ALU_WIDTH'($signed(a) < $signed(b));
            OP_GT:   alu_res = ALU_WIDTH'($signed(a) > $signed(b));
            default: alu_res = '0;
        endcase
    end

    // Outputs only move on a launch
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result <= '0;
            flags  <= '0;
        end else if (start) begin
            result         <= alu_res;
            flags.zero     <= (alu_res == '0);
            flags.overflow <= alu_ovf;
        end
    end

    // Illegal opcodes are filtered in the register block
    a_legal_op: assert property (
        @(posedge clk) disable iff (rst)
        start |-> op <= ALU_OP_LAST
    );

endmodule

//--- logic/alu_axil_top.sv
`timescale 1ns/1ps

module alu_axil_top
    import alu_pkg::*, axil_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic [AXIL_ADDR_W-1:0]   awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [AXIL_DATA_W-1:0]   wdata,
    input  logic [AXIL_DATA_W/8-1:0] wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready,
    input  logic [AXIL_ADDR_W-1:0]   araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output logic [AXIL_DATA_W-1:0]   rdata,
    output logic [1:0]               rresp,
    output logic                     rvalid,
    input  logic                     rready
);

    logic                 start;
    logic [ALU_WIDTH-1:0] a;
    logic [ALU_WIDTH-1:0] b;
    alu_op_e              op;
    logic [ALU_WIDTH-1:0] result;
    alu_flags_t           flags;

    reg_bus_if bus ();

    axil_slave u_slave (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .bus     (bus.host)
    );

    alu_regs u_regs (
        .clk    (clk),
        .rst    (rst),
        .bus    (bus.dev),
        .start  (start),
        .a      (a),
        .b      (b),
        .op     (op),
        .result (result),
        .flags  (flags)
    );

    alu_core u_core (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .a      (a),
        .b      (b),
        .op     (op),
        .result (result),
        .flags  (flags)
    );

endmodule

//--- verification/alu_tb_tasks.svh
`ifndef ALU_TB_TASKS_SVH
`define ALU_TB_TASKS_SVH

// Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        v = {v[30:0], fb};
    end
    return v;
endfunction

task automatic axil_write(input logic [AXIL_ADDR_W-1:0] addr, input logic [31:0] data,
                          input logic [3:0] strb, output axil_resp_e resp);
    int   stall;
    logic hs;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    hs = 1'b0;
    while (!hs) begin
        @(negedge clk);
        hs = awready && wready;
        @(posedge clk);
    end
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    // Hold off bready for a while
    stall = int'(rand_bits(3) % 6);
    repeat (stall) @(posedge clk);
    #1;
    bready = 1'b1;
    hs = 1'b0;
    while (!hs) begin
        @(negedge clk);
        hs = bvalid;
        resp = axil_resp_e'(bresp);
        @(posedge clk);
    end
    #1;
    bready = 1'b0;
endtask

task automatic axil_read(input logic [AXIL_ADDR_W-1:0] addr, output logic [31:0] data,
                         output axil_resp_e resp);
    int   stall;
    logic hs;
    araddr  = addr;
    arvalid = 1'b1;
    hs = 1'b0;
    while (!hs) begin
        @(negedge clk);
        hs = arready;
        @(posedge clk);
    end
    #1;
    arvalid = 1'b0;
    stall = int'(rand_bits(3) % 6);
    repeat (stall) @(posedge clk);
    #1;
    rready = 1'b1;
    hs = 1'b0;
    while (!hs) begin
        @(negedge clk);
        hs = rvalid;
        data = rdata;
        resp = axil_resp_e'(rresp);
        @(posedge clk);
    end
    #1;
    rready = 1'b0;
endtask

task automatic check_data(input string name, input logic [ALU_WIDTH-1:0] exp,
                          input logic [ALU_WIDTH-1:0] act);
    if (act !== exp) begin
        $display("Fail %s expected %h actual %h", name, exp, act);
        $display("sim failed");
        $fatal(1, "Data mismatch on %s", name);
    end
endtask

task automatic check_flags(input string name, input alu_flags_t exp, input alu_flags_t act);
    if (act !== exp) begin
        $display("Fail %s expected %h actual %h", name, exp, act);
        $display("sim failed");
        $fatal(1, "Flag mismatch on %s", name);
    end
endtask

task automatic check_resp(input string name, input axil_resp_e exp, input axil_resp_e act);
    if (act !== exp) begin
        $display("Fail %s expected %h actual %h", name, exp, act);
        $display("sim failed");
        $fatal(1, "Response mismatch on %s", name);
    end
endtask

`endif

//--- verification/alu_tb.sv
`timescale 1ns/1ps

module alu_tb
    import alu_pkg::*, axil_pkg::*;
();

    localparam int CLK_PERIOD = 8;
    localparam int N_RAND     = 300;
    localparam int N_STRB     = 40;
    // Reset reads, strobe tests, random ops, error tests with margin
    localparam int N_TXN      = 5 + N_STRB * 3 + N_RAND * 5 + 64;

    logic                     clk;
    logic                     rst;
    logic [AXIL_ADDR_W-1:0]   awaddr;
    logic                     awvalid;
    logic                     awready;
    logic [AXIL_DATA_W-1:0]   wdata;
    logic [AXIL_DATA_W/8-1:0] wstrb;
    logic                     wvalid;
    logic                     wready;
    logic [1:0]               bresp;
    logic                     bvalid;
    logic                     bready;
    logic [AXIL_ADDR_W-1:0]   araddr;
    logic                     arvalid;
    logic                     arready;
    logic [AXIL_DATA_W-1:0]   rdata;
    logic [1:0]               rresp;
    logic                     rvalid;
    logic                     rready;

    logic [31:0] lfsr_state = 32'h9d3d_54f5;

    // Reference model state
    logic [ALU_WIDTH-1:0] m_a;
    logic [ALU_WIDTH-1:0] m_b;
    logic [ALU_WIDTH-1:0] m_result;
    alu_op_e              m_op;
    alu_flags_t           m_flags;

    `include "alu_tb_tasks.svh"

    alu_axil_top uut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic void model_exec(input logic [31:0] x, input logic [31:0] y,
                                       input alu_op_e o, output logic [31:0] r,
                                       output alu_flags_t f);
        logic [32:0] wide;
        f = '0;
        r = '0;
        case (o)
            OP_ADD: begin
                wide = {x[31], x} + {y[31], y};
                r = wide[31:0];
                f.overflow = wide[32] ^ wide[31];
            end
            OP_SUB: begin
                wide = {x[31], x} - {y[31], y};
                r = wide[31:0];
                f.overflow = wide[32] ^ wide[31];
            end
            OP_AND:  r = x & y;
            OP_OR:   r = x | y;
            OP_XOR:  r = x ^ y;
            OP_NOT:  r = ~x;
            OP_EQ:   r = (x == y) ? 32'd1 : 32'd0;
            OP_LT:   r = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            OP_GT:   r = ($signed(x) > $signed(y)) ? 32'd1 : 32'd0;
            default: r = '0;
        endcase
        f.zero = (r == 32'd0);
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] nw,
                                                input logic [3:0] s);
        logic [31:0] mask;
        mask = {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
        return (old & ~mask) | (nw & mask);
    endfunction

    // Mostly random, now and then a corner value
    function automatic logic [31:0] pick_operand();
        logic [1:0] c;
        if (rand_bits(3) != 0) begin
            return rand_bits(32);
        end
        c = rand_bits(2);
        case (c)
            2'd0:    return 32'h7fff_ffff;
            2'd1:    return 32'h8000_0000;
            2'd2:    return 32'hffff_ffff;
            default: return 32'h0000_0000;
        endcase
    endfunction

    task automatic write_expect(input logic [7:0] addr, input logic [31:0] data,
                                input logic [3:0] strb, input axil_resp_e exp);
        axil_resp_e resp;
        axil_write(addr, data, strb, resp);
        check_resp($sformatf("bresp[%02h]", addr), exp, resp);
    endtask

    task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp);
        axil_resp_e  resp;
        logic [31:0] d;
        axil_read(addr, d, resp);
        check_resp($sformatf("rresp[%02h]", addr), OKAY, resp);
        check_data($sformatf("rdata[%02h]", addr), exp, d);
    endtask

    task automatic read_status();
        axil_resp_e  resp;
        logic [31:0] d;
        axil_read(REG_STATUS, d, resp);
        check_resp("rresp[status]", OKAY, resp);
        check_flags("status", m_flags, alu_flags_t'(d[1:0]));
        check_data("status[31:2]", '0, d >> 2);
    endtask

    task automatic read_error(input logic [7:0] addr);
        axil_resp_e  resp;
        logic [31:0] d;
        axil_read(addr, d, resp);
        check_resp($sformatf("rresp[%02h]", addr), SLVERR, resp);
    endtask

    task automatic run_op(input logic [31:0] va, input logic [31:0] vb, input alu_op_e o);
        logic [2:0] upper_strb;
        write_expect(REG_A, va, 4'hf, OKAY);
        m_a = va;
        write_expect(REG_B, vb, 4'hf, OKAY);
        m_b = vb;
        upper_strb = rand_bits(3);
        write_expect(REG_OP, 32'(o), {upper_strb, 1'b1}, OKAY);
        m_op = o;
        model_exec(m_a, m_b, m_op, m_result, m_flags);
        read_expect(REG_RESULT, m_result);
        read_status();
    endtask

    task automatic read_all();
        read_expect(REG_A, m_a);
        read_expect(REG_B, m_b);
        read_expect(REG_OP, 32'(m_op));
        read_expect(REG_RESULT, m_result);
        read_status();
    endtask

    initial begin
        logic [31:0] va;
        logic [31:0] vb;
        logic [31:0] wdat;
        logic [3:0]  s;
        logic        sel;
        clk     = 1'b0;
        rst     = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        m_a      = '0;
        m_b      = '0;
        m_result = '0;
        m_op     = OP_ADD;
        m_flags  = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        read_all();

        // Byte lane writes to the operands
        repeat (N_STRB) begin
            wdat = rand_bits(32);
            s    = rand_bits(4);
            sel  = rand_bits(1);
            write_expect(sel ? REG_B : REG_A, wdat, s, OKAY);
            if (sel) begin
                m_b = merge_bytes(m_b, wdat, s);
            end else begin
                m_a = merge_bytes(m_a, wdat, s);
            end
            read_expect(REG_A, m_a);
            read_expect(REG_B, m_b);
        end

        repeat (N_RAND) begin
            va = pick_operand();
            vb = (rand_bits(3) == 0) ? va : pick_operand();
            run_op(va, vb, alu_op_e'(rand_bits(4) % 9));
        end

        // Illegal opcodes leave result and status alone
        for (int v = ALU_OP_LAST + 1; v < 16; v++) begin
            write_expect(REG_OP, 32'(v), 4'hf, SLVERR);
            read_expect(REG_RESULT, m_result);
            read_status();
            read_expect(REG_OP, 32'(m_op));
        end
        write_expect(REG_OP, 32'(OP_SUB), 4'he, SLVERR);
        write_expect(REG_RESULT, rand_bits(32), 4'hf, SLVERR);
        write_expect(REG_STATUS, 32'h3, 4'hf, SLVERR);
        write_expect(8'h14, rand_bits(32), 4'hf, SLVERR);
        write_expect(8'h02, rand_bits(32), 4'hf, SLVERR);
        write_expect(8'hfc, rand_bits(32), 4'hf, SLVERR);
        read_error(8'h14);
        read_error(8'h40);
        read_all();

        $display("sim passed");
        $finish;
    end

    initial begin
        #(CLK_PERIOD * 200 * N_TXN);
        $display("Bus hung, a transaction never completed within the time limit");
        $display("sim failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

//--- build.f
+incdir+verification
logic/alu_pkg.sv
logic/axil_pkg.sv
logic/reg_bus_if.sv
logic/axil_slave.sv
logic/alu_regs.sv
logic/alu_core.sv
logic/alu_axil_top.sv
verification/alu_tb.sv
